// ==== include/sram_tc_params.svh ====
`ifndef SRAM_TC_PARAMS_SVH
`define SRAM_TC_PARAMS_SVH

// Number of SRAM banks, a power of two from 2 to 16
`define SRAM_TC_NUM_BANKS 4

// Bank select width, log2 of the bank count
`define SRAM_TC_SEL_W 2

// Word address width per bank
`define SRAM_TC_ADDR_W 4

// Word width
`define SRAM_TC_DATA_W 32

// One mask bit per byte
`define SRAM_TC_MASK_W (`SRAM_TC_DATA_W / 8)

`endif

// ==== hdl/sram_tc_pkg.sv ====
`include "sram_tc_params.svh"

package sram_tc_pkg;

   // One port command as seen by every bank
   typedef struct packed {
      logic [`SRAM_TC_ADDR_W-1:0] addr;
      logic [`SRAM_TC_DATA_W-1:0] din;
      logic                       csb;
      logic                       web;
      logic [`SRAM_TC_MASK_W-1:0] wmask;
   } port_cmd_t;

   // Full instruction register, bank select on top
   typedef struct packed {
      logic [`SRAM_TC_SEL_W-1:0] bank_sel;
      port_cmd_t                 port0;
      port_cmd_t                 port1;
   } instr_t;

   // Registered read words of one bank
   typedef struct packed {
      logic [`SRAM_TC_DATA_W-1:0] dout0;
      logic [`SRAM_TC_DATA_W-1:0] dout1;
   } bank_dout_t;

   // Register operation picked each cycle
   typedef enum logic [1:0] {
      OP_HOLD,
      OP_SCAN,
      OP_LOAD,
      OP_CAPTURE
   } reg_op_e;

endpackage

// ==== hdl/command_register.sv ====
`include "sram_tc_params.svh"

module command_register (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               scan_en,
   input  logic                               scan_in,
   input  logic                               load_en,
   input  sram_tc_pkg::instr_t                load_data,
   input  logic                               capture_en,
   input  sram_tc_pkg::bank_dout_t            capt_data,
   output sram_tc_pkg::instr_t                instr_out,
   output logic                               scan_out,
   output sram_tc_pkg::port_cmd_t             cmd0,
   output sram_tc_pkg::port_cmd_t             cmd1,
   output logic [`SRAM_TC_NUM_BANKS-1:0]      csb0_vec,
   output logic [`SRAM_TC_NUM_BANKS-1:0]      csb1_vec,
   output logic [`SRAM_TC_SEL_W-1:0]          bank_sel
);

   localparam int INSTR_W = $bits(sram_tc_pkg::instr_t);

   sram_tc_pkg::reg_op_e op;
   sram_tc_pkg::instr_t  instr_q;

   // Scan beats load, load beats capture
   always_comb begin
      if (scan_en) begin
         op = sram_tc_pkg::OP_SCAN;
      end else if (load_en) begin
         op = sram_tc_pkg::OP_LOAD;
      end else if (capture_en) begin
         op = sram_tc_pkg::OP_CAPTURE;
      end else begin
         op = sram_tc_pkg::OP_HOLD;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         // Both ports deselected out of reset
         instr_q           <= '0;
         instr_q.port0.csb <= 1'b1;
         instr_q.port1.csb <= 1'b1;
      end else begin
         case (op)
            sram_tc_pkg::OP_SCAN: begin
               instr_q <= {instr_q[INSTR_W-2:0], scan_in};
            end
            sram_tc_pkg::OP_LOAD: begin
               instr_q <= load_data;
            end
            sram_tc_pkg::OP_CAPTURE: begin
               // Read words land in the din fields
               instr_q.port0.din <= capt_data.dout0;
               instr_q.port1.din <= capt_data.dout1;
            end
            default: begin
               instr_q <= instr_q;
            end
         endcase
      end
   end

   assign instr_out = instr_q;
   assign scan_out  = instr_q[INSTR_W-1];
   assign cmd0      = instr_q.port0;
   assign cmd1      = instr_q.port1;
   assign bank_sel  = instr_q.bank_sel;

   // Active port select moved to the chosen bank, then inverted to one-cold
   assign csb0_vec = ~({{(`SRAM_TC_NUM_BANKS-1){1'b0}}, ~instr_q.port0.csb} << instr_q.bank_sel);
   assign csb1_vec = ~({{(`SRAM_TC_NUM_BANKS-1){1'b0}}, ~instr_q.port1.csb} << instr_q.bank_sel);

   // Strobes and the data taken by the chosen op must be known
   a_inputs_known: assert property (
      @(posedge clk) disable iff (reset)
      !$isunknown({scan_en, load_en, capture_en})
      && (op != sram_tc_pkg::OP_SCAN || !$isunknown(scan_in))
      && (op != sram_tc_pkg::OP_LOAD || !$isunknown(load_data))
   );

endmodule

// ==== hdl/sram_bank.sv ====
`include "sram_tc_params.svh"

module sram_bank (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    csb0,
   input  logic                    csb1,
   input  sram_tc_pkg::port_cmd_t  cmd0,
   input  sram_tc_pkg::port_cmd_t  cmd1,
   output sram_tc_pkg::bank_dout_t dout
);

   localparam int DEPTH = 1 << `SRAM_TC_ADDR_W;

   logic [`SRAM_TC_DATA_W-1:0] mem [DEPTH];

   // Byte-masked writes
   // Port1 assignments come last so its bytes win on a shared address
   always_ff @(posedge clk) begin
      if (!csb0 && !cmd0.web) begin
         for (int b = 0; b < `SRAM_TC_MASK_W; b++) begin
            if (cmd0.wmask[b]) begin
               mem[cmd0.addr][b*8 +: 8] <= cmd0.din[b*8 +: 8];
            end
         end
      end
      if (!csb1 && !cmd1.web) begin
         for (int b = 0; b < `SRAM_TC_MASK_W; b++) begin
            if (cmd1.wmask[b]) begin
               mem[cmd1.addr][b*8 +: 8] <= cmd1.din[b*8 +: 8];
            end
         end
      end
   end

   // Registered reads see the contents before this edge's writes
   always_ff @(posedge clk) begin
      if (reset) begin
         dout <= '0;
      end else begin
         if (!csb0) begin
            dout.dout0 <= mem[cmd0.addr];
         end
         if (!csb1) begin
            dout.dout1 <= mem[cmd1.addr];
         end
      end
   end

   // Port0 select and command must be clean whenever the bank is driven
   a_port0_known: assert property (
      @(posedge clk) disable iff (reset)
      !$isunknown(csb0) && (csb0 || !$isunknown(cmd0))
   );

endmodule

// ==== hdl/read_capture.sv ====
`include "sram_tc_params.svh"

module read_capture (
   input  logic [`SRAM_TC_SEL_W-1:0] bank_sel,
   input  sram_tc_pkg::bank_dout_t   bank_douts [`SRAM_TC_NUM_BANKS],
   output sram_tc_pkg::bank_dout_t   capt_data
);

   // Pick the addressed bank's read words
   always_comb begin
      capt_data = '0;
      for (int i = 0; i < `SRAM_TC_NUM_BANKS; i++) begin
         if (bank_sel == `SRAM_TC_SEL_W'(i)) begin
            capt_data = bank_douts[i];
         end
      end
   end

   // Select field must name an existing bank
   always_comb begin
      a_bank_sel_range: assert (int'(bank_sel) < `SRAM_TC_NUM_BANKS);
   end

endmodule

// ==== hdl/sram_testchip_top.sv ====
`include "sram_tc_params.svh"

module sram_testchip_top (
   input  logic                clk,
   input  logic                reset,
   input  logic                scan_en,
   input  logic                scan_in,
   input  logic                load_en,
   input  sram_tc_pkg::instr_t load_data,
   input  logic                capture_en,
   output logic                scan_out,
   output sram_tc_pkg::instr_t instr_out
);

   sram_tc_pkg::port_cmd_t        cmd0;
   sram_tc_pkg::port_cmd_t        cmd1;
   logic [`SRAM_TC_NUM_BANKS-1:0] csb0_vec;
   logic [`SRAM_TC_NUM_BANKS-1:0] csb1_vec;
   logic [`SRAM_TC_SEL_W-1:0]     bank_sel;
   sram_tc_pkg::bank_dout_t       bank_douts [`SRAM_TC_NUM_BANKS];
   sram_tc_pkg::bank_dout_t       capt_data;

   command_register command_register_inst (
      .clk        (clk),
      .reset      (reset),
      .scan_en    (scan_en),
      .scan_in    (scan_in),
      .load_en    (load_en),
      .load_data  (load_data),
      .capture_en (capture_en),
      .capt_data  (capt_data),
      .instr_out  (instr_out),
      .scan_out   (scan_out),
      .cmd0       (cmd0),
      .cmd1       (cmd1),
      .csb0_vec   (csb0_vec),
      .csb1_vec   (csb1_vec),
      .bank_sel   (bank_sel)
   );

   // Banks share both commands, only the chip selects differ
   for (genvar b = 0; b < `SRAM_TC_NUM_BANKS; b++) begin : gen_bank
      sram_bank sram_bank_inst (
         .clk   (clk),
         .reset (reset),
         .csb0  (csb0_vec[b]),
         .csb1  (csb1_vec[b]),
         .cmd0  (cmd0),
         .cmd1  (cmd1),
         .dout  (bank_douts[b])
      );
   end

   read_capture read_capture_inst (
      .bank_sel   (bank_sel),
      .bank_douts (bank_douts),
      .capt_data  (capt_data)
   );

endmodule

// ==== include/sram_tc_model.svh ====
`ifndef SRAM_TC_MODEL_SVH
`define SRAM_TC_MODEL_SVH

`include "sram_tc_params.svh"

localparam int INSTR_W = $bits(sram_tc_pkg::instr_t);
localparam int DEPTH   = 1 << `SRAM_TC_ADDR_W;

// Expected register, memories and bank read registers
sram_tc_pkg::instr_t        model_instr;
logic [`SRAM_TC_DATA_W-1:0] model_mem [`SRAM_TC_NUM_BANKS][DEPTH];
sram_tc_pkg::bank_dout_t    model_dout [`SRAM_TC_NUM_BANKS];

// Fibonacci LFSR, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd42;

function automatic logic random_bit();
   logic fb;
   fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
   lfsr_state = {lfsr_state[14:0], fb};
   return fb;
endfunction

function automatic sram_tc_pkg::instr_t random_instr();
   sram_tc_pkg::instr_t v;
   v = '0;
   for (int i = 0; i < INSTR_W; i++) begin
      v = {v[INSTR_W-2:0], random_bit()};
   end
   return v;
endfunction

function automatic void model_reset();
   model_instr           = '0;
   model_instr.port0.csb = 1'b1;
   model_instr.port1.csb = 1'b1;
   for (int b = 0; b < `SRAM_TC_NUM_BANKS; b++) begin
      model_dout[b] = '0;
   end
endfunction

function automatic void write_bytes(input logic [`SRAM_TC_SEL_W-1:0] b,
                                    input sram_tc_pkg::port_cmd_t cmd);
   for (int i = 0; i < `SRAM_TC_MASK_W; i++) begin
      if (cmd.wmask[i]) begin
         model_mem[b][cmd.addr][i*8 +: 8] = cmd.din[i*8 +: 8];
      end
   end
endfunction

// One clock edge, bank access with the current word then the register update
function automatic void model_step(input logic s_en, input logic s_in, input logic l_en,
                                   input sram_tc_pkg::instr_t l_data, input logic c_en);
   sram_tc_pkg::reg_op_e      op;
   sram_tc_pkg::bank_dout_t   capt;
   logic [`SRAM_TC_SEL_W-1:0] b;
   b    = model_instr.bank_sel;
   capt = model_dout[b];
   // Old contents are read before either write lands
   if (!model_instr.port0.csb) begin
      model_dout[b].dout0 = model_mem[b][model_instr.port0.addr];
   end
   if (!model_instr.port1.csb) begin
      model_dout[b].dout1 = model_mem[b][model_instr.port1.addr];
   end
   if (!model_instr.port0.csb && !model_instr.port0.web) begin
      write_bytes(b, model_instr.port0);
   end
   // port1 goes second so its bytes stay on top
   if (!model_instr.port1.csb && !model_instr.port1.web) begin
      write_bytes(b, model_instr.port1);
   end
   if (s_en) begin
      op = sram_tc_pkg::OP_SCAN;
   end else if (l_en) begin
      op = sram_tc_pkg::OP_LOAD;
   end else if (c_en) begin
      op = sram_tc_pkg::OP_CAPTURE;
   end else begin
      op = sram_tc_pkg::OP_HOLD;
   end
   case (op)
      sram_tc_pkg::OP_SCAN: model_instr = {model_instr[INSTR_W-2:0], s_in};
      sram_tc_pkg::OP_LOAD: model_instr = l_data;
      sram_tc_pkg::OP_CAPTURE: begin
         model_instr.port0.din = capt.dout0;
         model_instr.port1.din = capt.dout1;
      end
      default: model_instr = model_instr;
   endcase
endfunction

`endif

// ==== verification/sram_testchip_tb.sv ====
`include "sram_tc_params.svh"

module sram_testchip_tb;

   logic                clk;
   logic                reset;
   logic                scan_en;
   logic                scan_in;
   logic                load_en;
   sram_tc_pkg::instr_t load_data;
   logic                capture_en;
   logic                scan_out;
   sram_tc_pkg::instr_t instr_out;

   `include "sram_tc_model.svh"

   // Reset, fill, load 20, scan, write/read 40*5, collision 8*8, priority 60, margin
   localparam int LIMIT_CYCLES = 3 + `SRAM_TC_NUM_BANKS * DEPTH + 20 + INSTR_W + 40 * 5
                                 + 8 * 8 + 60 + 50;

   int cycle_count  = 0;
   int test_errors  = 0;
   int total_errors = 0;
   int tests_run    = 0;
   int tests_failed = 0;

   sram_testchip_top sram_testchip_top_inst (
      .clk        (clk),
      .reset      (reset),
      .scan_en    (scan_en),
      .scan_in    (scan_in),
      .load_en    (load_en),
      .load_data  (load_data),
      .capture_en (capture_en),
      .scan_out   (scan_out),
      .instr_out  (instr_out)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > LIMIT_CYCLES) begin
         $display("Run stopped: no result after %0d cycles", LIMIT_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   // Called on a falling edge, returns on the next one
   task automatic run_cycle(input logic s_en, input logic s_in, input logic l_en,
                            input sram_tc_pkg::instr_t l_data, input logic c_en);
      scan_en    = s_en;
      scan_in    = s_in;
      load_en    = l_en;
      load_data  = l_data;
      capture_en = c_en;
      @(posedge clk);
      model_step(s_en, s_in, l_en, l_data, c_en);
      @(negedge clk);
   endtask

   task automatic load_instr(input sram_tc_pkg::instr_t instr);
      run_cycle(1'b0, 1'b0, 1'b1, instr, 1'b0);
   endtask

   task automatic hold_cycle();
      run_cycle(1'b0, 1'b0, 1'b0, '0, 1'b0);
   endtask

   // Load edge, one access edge, then capture
   task automatic read_back(input sram_tc_pkg::instr_t instr);
      load_instr(instr);
      hold_cycle();
      run_cycle(1'b0, 1'b0, 1'b0, '0, 1'b1);
   endtask

   task automatic check_state();
      if (instr_out !== model_instr) begin
         $display("Error at %0t: instr_out is %h, expected %h", $time, instr_out, model_instr);
         test_errors++;
      end
      if (scan_out !== model_instr[INSTR_W-1]) begin
         $display("Error at %0t: scan_out is %b, expected %b", $time, scan_out,
                  model_instr[INSTR_W-1]);
         test_errors++;
      end
   endtask

   task automatic check_word(input string name, input logic [`SRAM_TC_DATA_W-1:0] got,
                             input logic [`SRAM_TC_DATA_W-1:0] expected);
      if (got !== expected) begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
         test_errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("Test %s: passed", name);
      end else begin
         $display("Test %s: failed with %0d errors", name, test_errors);
         tests_failed++;
      end
      total_errors += test_errors;
      test_errors = 0;
   endtask

   initial begin
      sram_tc_pkg::instr_t        instr;
      sram_tc_pkg::instr_t        rd;
      sram_tc_pkg::instr_t        shifted;
      sram_tc_pkg::instr_t        pending [$];
      logic [`SRAM_TC_DATA_W-1:0] merged;
      logic                       s;
      logic                       si;
      logic                       l;
      logic                       c;
      clk        = 1'b0;
      reset      = 1'b1;
      scan_en    = 1'b0;
      scan_in    = 1'b0;
      load_en    = 1'b0;
      load_data  = '0;
      capture_en = 1'b0;
      model_reset();
      repeat (2) @(negedge clk);
      reset = 1'b0;
      check_state();
      end_test("reset");

      // Known contents everywhere, pattern from bank and word address
      for (int w = 0; w < `SRAM_TC_NUM_BANKS * DEPTH; w += 2) begin
         instr             = '0;
         instr.bank_sel    = `SRAM_TC_SEL_W'(w / DEPTH);
         instr.port0.addr  = `SRAM_TC_ADDR_W'(w % DEPTH);
         instr.port0.din   = 32'hF1110000 | `SRAM_TC_DATA_W'(w);
         instr.port0.wmask = '1;
         instr.port1       = instr.port0;
         instr.port1.addr  = `SRAM_TC_ADDR_W'((w + 1) % DEPTH);
         instr.port1.din   = 32'hF1110000 | `SRAM_TC_DATA_W'(w + 1);
         load_instr(instr);
         hold_cycle();
      end

      for (int i = 0; i < 20; i++) begin
         load_instr(random_instr());
         check_state();
      end
      end_test("parallel_load");

      shifted = '0;
      for (int i = 0; i < INSTR_W; i++) begin
         si      = random_bit();
         shifted = {shifted[INSTR_W-2:0], si};
         run_cycle(1'b1, si, 1'b0, '0, 1'b0);
         check_state();
      end
      if (instr_out !== shifted) begin
         $display("Error at %0t: instr_out is %h, expected %h", $time, instr_out, shifted);
         test_errors++;
      end
      end_test("scan");

      for (int i = 0; i < 40; i++) begin
         instr           = random_instr();
         instr.port0.csb = 1'b0;
         instr.port0.web = 1'b0;
         instr.port1.csb = random_bit();
         instr.port1.web = 1'b0;
         load_instr(instr);
         hold_cycle();
         pending.push_back(instr);
      end
      while (pending.size() > 0) begin
         rd           = pending.pop_front();
         rd.port0.web = 1'b1;
         rd.port1.csb = 1'b0;
         rd.port1.web = 1'b1;
         read_back(rd);
         check_state();
         check_word("port0.din", instr_out.port0.din, model_mem[rd.bank_sel][rd.port0.addr]);
         check_word("port1.din", instr_out.port1.din, model_mem[rd.bank_sel][rd.port1.addr]);
      end
      end_test("write_read");

      for (int i = 0; i < 8; i++) begin
         instr             = random_instr();
         instr.port1.addr  = instr.port0.addr;
         instr.port0.wmask = instr.port0.wmask | 4'b0110;
         instr.port1.wmask = instr.port1.wmask | 4'b0011;
         instr.port0.csb   = 1'b0;
         instr.port0.web   = 1'b0;
         instr.port1.csb   = 1'b0;
         instr.port1.web   = 1'b0;
         load_instr(instr);
         hold_cycle();
         merged = model_mem[instr.bank_sel][instr.port0.addr];
         rd           = instr;
         rd.port0.web = 1'b1;
         rd.port1.web = 1'b1;
         read_back(rd);
         check_state();
         check_word("port0.din", instr_out.port0.din, merged);
         check_word("port1.din", instr_out.port1.din, merged);
         // port0 reads the word that port1 is overwriting
         rd.port1.web   = 1'b0;
         rd.port1.wmask = '1;
         rd.port1.din   = ~merged;
         read_back(rd);
         check_state();
         check_word("port0.din", instr_out.port0.din, merged);
      end
      end_test("collision");

      for (int i = 0; i < 60; i++) begin
         s     = random_bit();
         si    = random_bit();
         l     = random_bit();
         c     = random_bit();
         instr = random_instr();
         run_cycle(s, si, l, instr, c);
         check_state();
      end
      end_test("strobe_priority");

      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
               total_errors);
      if (total_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+include
hdl/sram_tc_pkg.sv
hdl/command_register.sv
hdl/sram_bank.sv
hdl/read_capture.sv
hdl/sram_testchip_top.sv
verification/sram_testchip_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sram_testchip_tb
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
